//--- hw/rename_pkg.sv
//==========================================================================
// rename package
// widths, register counts and the rob entry state shared by the
// register renaming core
//==========================================================================
`default_nettype none

package rename_pkg;

	//==========================================================================
	// register file sizes
	//==========================================================================
	parameter int AREG_W = 5;				// arch reg index
	parameter int N_AREG = 32;
	parameter int PREG_W = 6;				// phys reg tag
	parameter int N_PREG = 64;

	// pregs not mapped at reset sit in the free list
	parameter int N_FREE = N_PREG - N_AREG;

	// hardwired zero, never renamed
	parameter int ZERO_REG = 31;

	typedef logic [AREG_W-1:0] areg_t;
	typedef logic [PREG_W-1:0] preg_t;

	//==========================================================================
	// rob entry state
	//==========================================================================
	typedef enum logic [1:0] {
		ROB_EMPTY	= 2'd0,			// slot free
		ROB_PENDING	= 2'd1,			// dispatched, waiting on cdb
		ROB_DONE	= 2'd2			// completed, may retire
	} rob_state_e;

endpackage : rename_pkg

`default_nettype wire

//--- hw/map_table.sv
//==========================================================================
// map table
// architectural to physical register map plus one ready bit per preg.
// source lookups are combinational and see the map before this cycle's
// rename; a cdb broadcast in the same cycle is forwarded to the source
// ready outputs
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module map_table
	import rename_pkg::*;
(
	input	wire			clk,
	input	wire			rst_i,

	// lookup side, from dispatch
	input	wire areg_t		opa_areg_i,
	input	wire areg_t		opb_areg_i,
	input	wire areg_t		dest_areg_i,
	input	wire			rename_en_i,		// accepted and dest != zero reg
	input	wire preg_t		new_preg_i,			// free list head

	// completion
	input	wire			cdb_vld_i,
	input	wire preg_t		cdb_tag_i,

	output	preg_t			opa_preg_o,
	output	preg_t			opb_preg_o,
	output	preg_t			old_preg_o,			// previous dest mapping, to rob
	output	logic			opa_rdy_o,
	output	logic			opb_rdy_o
);

	preg_t				map_q [N_AREG];		// current speculative map
	logic [N_PREG-1:0]	rdy_q;				// value produced

	//==========================================================================
	// lookup
	//==========================================================================
	assign opa_preg_o = map_q[opa_areg_i];
	assign opb_preg_o = map_q[opb_areg_i];
	assign old_preg_o = map_q[dest_areg_i];

	// ready if already written back or broadcast this very cycle
	assign opa_rdy_o = rdy_q[opa_preg_o] | (cdb_vld_i && (cdb_tag_i == opa_preg_o));
	assign opb_rdy_o = rdy_q[opb_preg_o] | (cdb_vld_i && (cdb_tag_i == opb_preg_o));

	//==========================================================================
	// map update
	//==========================================================================
	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < N_AREG; i++) begin
				map_q[i] <= preg_t'(i);		// identity map
			end
		end else if (rename_en_i) begin
			map_q[dest_areg_i] <= new_preg_i;
		end
	end

	//==========================================================================
	// ready bits
	//==========================================================================
	always_ff @(posedge clk) begin
		if (rst_i) begin
			rdy_q <= '1;					// all arch values valid
		end else begin
			if (cdb_vld_i)
				rdy_q[cdb_tag_i] <= 1'b1;
			// new tag is not produced yet, last write wins
			if (rename_en_i)
				rdy_q[new_preg_i] <= 1'b0;
		end
	end

endmodule : map_table

`default_nettype wire

//--- hw/free_list.sv
//==========================================================================
// free list
// circular fifo of unmapped physical registers. pops hand out the head
// tag on rename, pushes return old tags from retirement
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module free_list
	import rename_pkg::*;
(
	input	wire			clk,
	input	wire			rst_i,

	input	wire			pop_i,				// rename with a dest
	input	wire			push_i,				// retire with a dest
	input	wire preg_t		push_preg_i,		// old tag freed by retire

	output	preg_t			head_preg_o,
	output	logic			empty_o
);

	localparam int PTR_W = $clog2(N_FREE);

	preg_t				fl_mem [N_FREE];
	logic [PTR_W-1:0]	head_q;
	logic [PTR_W-1:0]	tail_q;
	logic [PTR_W:0]		count_q;			// 0 .. N_FREE

	logic				pop_ok;

	assign head_preg_o	= fl_mem[head_q];
	assign empty_o		= (count_q == '0);	// registered count only

	// never read past the last entry
	assign pop_ok = pop_i && !empty_o;

	//==========================================================================
	// storage
	//==========================================================================
	always_ff @(posedge clk) begin
		if (rst_i) begin
			// pregs N_AREG .. N_PREG-1 free, ascending
			for (int i = 0; i < N_FREE; i++) begin
				fl_mem[i] <= preg_t'(N_AREG + i);
			end
		end else if (push_i) begin
			fl_mem[tail_q] <= push_preg_i;
		end
	end

	//==========================================================================
	// pointers and count
	//==========================================================================
	always_ff @(posedge clk) begin
		if (rst_i) begin
			head_q	<= '0;
			tail_q	<= '0;				// full, tail wrapped onto head
			count_q	<= (PTR_W+1)'(N_FREE);
		end else begin
			if (pop_ok)
				head_q <= head_q + 1'b1;	// power of two, wraps
			if (push_i)
				tail_q <= tail_q + 1'b1;

			if (pop_ok && !push_i)
				count_q <= count_q - 1'b1;
			else if (push_i && !pop_ok)
				count_q <= count_q + 1'b1;
		end
	end

endmodule : free_list

`default_nettype wire

//--- hw/reorder_buffer.sv
//==========================================================================
// reorder buffer
// circular buffer, entries allocated at the tail on dispatch, marked
// done by index from the cdb and retired from the head in order, at
// most one per cycle
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer
	import rename_pkg::*;
#(
	parameter int	ROB_DEPTH = 16,				// power of two
	localparam int	IDX_W = $clog2(ROB_DEPTH)
) (
	input	wire				clk,
	input	wire				rst_i,

	// allocate
	input	wire				push_i,
	input	wire areg_t			push_areg_i,
	input	wire preg_t			push_preg_i,		// new tag
	input	wire preg_t			push_old_preg_i,	// tag it replaces
	input	wire				push_has_dest_i,

	// completion
	input	wire				done_vld_i,
	input	wire [IDX_W-1:0]	done_idx_i,

	output	logic [IDX_W-1:0]	tail_idx_o,
	output	logic				full_o,

	// retire, head entry
	output	logic				retire_vld_o,
	output	areg_t				retire_areg_o,
	output	preg_t				retire_preg_o,
	output	preg_t				retire_old_preg_o,
	output	logic				retire_has_dest_o
);

	//==========================================================================
	// entry storage
	//==========================================================================
	rob_state_e			state_q [ROB_DEPTH];	// control, reset
	areg_t				areg_q [ROB_DEPTH];		// payload, no reset
	preg_t				preg_q [ROB_DEPTH];
	preg_t				old_preg_q [ROB_DEPTH];
	logic				has_dest_q [ROB_DEPTH];

	logic [IDX_W-1:0]	head_q;
	logic [IDX_W-1:0]	tail_q;
	logic [IDX_W:0]		count_q;				// 0 .. ROB_DEPTH

	logic				push_ok;
	logic				pop;

	assign full_o		= (count_q == (IDX_W+1)'(ROB_DEPTH));
	assign tail_idx_o	= tail_q;
	assign push_ok		= push_i && !full_o;

	// head done -> retire, the pop follows at the edge
	assign retire_vld_o			= (state_q[head_q] == ROB_DONE);
	assign retire_areg_o		= areg_q[head_q];
	assign retire_preg_o		= preg_q[head_q];
	assign retire_old_preg_o	= old_preg_q[head_q];
	assign retire_has_dest_o	= has_dest_q[head_q];
	assign pop					= retire_vld_o;

	//==========================================================================
	// entry state
	//==========================================================================
	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < ROB_DEPTH; i++) begin
				state_q[i] <= ROB_EMPTY;
			end
		end else begin
			if (pop)
				state_q[head_q] <= ROB_EMPTY;
			if (done_vld_i)
				state_q[done_idx_i] <= ROB_DONE;	// any order
			if (push_ok)
				state_q[tail_q] <= ROB_PENDING;
		end
	end

	// destination fields written once at allocate
	always_ff @(posedge clk) begin
		if (push_ok) begin
			areg_q[tail_q]		<= push_areg_i;
			preg_q[tail_q]		<= push_preg_i;
			old_preg_q[tail_q]	<= push_old_preg_i;
			has_dest_q[tail_q]	<= push_has_dest_i;
		end
	end

	//==========================================================================
	// pointers and occupancy
	//==========================================================================
	always_ff @(posedge clk) begin
		if (rst_i) begin
			head_q	<= '0;
			tail_q	<= '0;
			count_q	<= '0;
		end else begin
			if (push_ok)
				tail_q <= tail_q + 1'b1;
			if (pop)
				head_q <= head_q + 1'b1;

			// full stays full through a retire cycle, no push then
			if (push_ok && !pop)
				count_q <= count_q + 1'b1;
			else if (pop && !push_ok)
				count_q <= count_q - 1'b1;
		end
	end

endmodule : reorder_buffer

`default_nettype wire

//--- hw/rename_core.sv
//==========================================================================
// rename core
// top level of the register renaming block. dispatch stall and accept
// logic, map table, free list and reorder buffer. decoded instructions
// come in as arch indices, completion comes in on the cdb, retirement
// leaves in order and returns old tags to the free list
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module rename_core
	import rename_pkg::*;
#(
	parameter int	ROB_DEPTH = 16,
	localparam int	ROB_IDX_W = $clog2(ROB_DEPTH)
) (
	input	wire					clk,
	input	wire					rst_i,

	// dispatch
	input	wire					dispatch_vld_i,
	input	wire areg_t				opa_areg_i,
	input	wire areg_t				opb_areg_i,
	input	wire areg_t				dest_areg_i,
	output	logic					dispatch_rdy_o,

	// rename result, same cycle
	output	preg_t					opa_preg_o,
	output	preg_t					opb_preg_o,
	output	preg_t					dest_preg_o,
	output	logic					opa_rdy_o,
	output	logic					opb_rdy_o,
	output	logic [ROB_IDX_W-1:0]	rob_idx_o,

	// cdb
	input	wire					cdb_vld_i,
	input	wire preg_t				cdb_tag_i,
	input	wire [ROB_IDX_W-1:0]	cdb_rob_idx_i,

	// retire
	output	logic					retire_vld_o,
	output	areg_t					retire_areg_o,
	output	preg_t					retire_preg_o,
	output	preg_t					retire_old_preg_o,
	output	logic					retire_has_dest_o
);

	logic		has_dest;			// dest is not the zero reg
	logic		rob_full;
	logic		fl_empty;
	logic		accept;
	logic		rename_en;
	logic		fl_push;
	preg_t		fl_head_preg;
	preg_t		old_preg;			// dest mapping before this rename

	//==========================================================================
	// dispatch stall / accept
	//==========================================================================
	assign has_dest = (dest_areg_i != areg_t'(ZERO_REG));

	// empty free list only blocks instrs that need a new tag
	assign dispatch_rdy_o	= !rob_full && !(fl_empty && has_dest);
	assign accept			= dispatch_vld_i && dispatch_rdy_o;
	assign rename_en		= accept && has_dest;	// map write + fl pop

	// no dest -> report the zero reg mapping, nothing consumed
	assign dest_preg_o = has_dest ? fl_head_preg : old_preg;

	// old tag back to the free list
	assign fl_push = retire_vld_o && retire_has_dest_o;

	//==========================================================================
	// map table
	//==========================================================================
	map_table map_table_i (
		.clk			(clk),
		.rst_i			(rst_i),
		.opa_areg_i		(opa_areg_i),
		.opb_areg_i		(opb_areg_i),
		.dest_areg_i	(dest_areg_i),
		.rename_en_i	(rename_en),
		.new_preg_i		(fl_head_preg),
		.cdb_vld_i		(cdb_vld_i),
		.cdb_tag_i		(cdb_tag_i),
		.opa_preg_o		(opa_preg_o),
		.opb_preg_o		(opb_preg_o),
		.old_preg_o		(old_preg),
		.opa_rdy_o		(opa_rdy_o),
		.opb_rdy_o		(opb_rdy_o)
	);

	//==========================================================================
	// free list
	//==========================================================================
	free_list free_list_i (
		.clk			(clk),
		.rst_i			(rst_i),
		.pop_i			(rename_en),
		.push_i			(fl_push),
		.push_preg_i	(retire_old_preg_o),
		.head_preg_o	(fl_head_preg),
		.empty_o		(fl_empty)
	);

	//==========================================================================
	// reorder buffer
	//==========================================================================
	reorder_buffer #(
		.ROB_DEPTH		(ROB_DEPTH)
	) reorder_buffer_i (
		.clk				(clk),
		.rst_i				(rst_i),
		.push_i				(accept),
		.push_areg_i		(dest_areg_i),
		.push_preg_i		(dest_preg_o),
		.push_old_preg_i	(old_preg),
		.push_has_dest_i	(has_dest),
		.done_vld_i			(cdb_vld_i),		// completion marks entry done
		.done_idx_i			(cdb_rob_idx_i),
		.tail_idx_o			(rob_idx_o),
		.full_o				(rob_full),
		.retire_vld_o		(retire_vld_o),
		.retire_areg_o		(retire_areg_o),
		.retire_preg_o		(retire_preg_o),
		.retire_old_preg_o	(retire_old_preg_o),
		.retire_has_dest_o	(retire_has_dest_o)
	);

endmodule : rename_core

`default_nettype wire

//--- bench/rename_core_properties.sv
//==========================================================================
// rename core properties
// concurrent checks on the dispatch and retire ports of rename_core
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module rename_core_properties
	import rename_pkg::*;
(
	input	wire			clk,
	input	wire			rst_i,
	input	wire			accept_i,			// dispatch taken this cycle
	input	wire			has_dest_i,
	input	wire			dispatch_rdy_i,
	input	wire preg_t		opa_preg_i,
	input	wire preg_t		opb_preg_i,
	input	wire preg_t		dest_preg_i,
	input	wire			retire_vld_i,
	input	wire			retire_has_dest_i,
	input	wire preg_t		retire_preg_i,
	input	wire preg_t		retire_old_preg_i
);

	int		fail_count = 0;		// number of failed checks

	// nothing stalls and nothing retires in the first cycle out of reset
	assert property (@(posedge clk) $fell(rst_i) |-> dispatch_rdy_i && !retire_vld_i)
		else begin
			fail_count++;
			$error("dispatch or retire state wrong right after reset");
		end

	// new tag comes off the free list and is never a mapped one
	assert property (@(posedge clk) disable iff (rst_i)
		(accept_i && has_dest_i) |-> (dest_preg_i != opa_preg_i) && (dest_preg_i != opb_preg_i))
		else begin
			fail_count++;
			$error("new dest tag equals a source tag");
		end

	// old and new tag of one rename are distinct
	assert property (@(posedge clk) disable iff (rst_i)
		(retire_vld_i && retire_has_dest_i) |-> (retire_old_preg_i != retire_preg_i))
		else begin
			fail_count++;
			$error("retired old tag equals its new tag");
		end

endmodule : rename_core_properties

bind rename_core rename_core_properties props_i (
	.clk				(clk),
	.rst_i				(rst_i),
	.accept_i			(accept),
	.has_dest_i			(has_dest),
	.dispatch_rdy_i		(dispatch_rdy_o),
	.opa_preg_i			(opa_preg_o),
	.opb_preg_i			(opb_preg_o),
	.dest_preg_i		(dest_preg_o),
	.retire_vld_i		(retire_vld_o),
	.retire_has_dest_i	(retire_has_dest_o),
	.retire_preg_i		(retire_preg_o),
	.retire_old_preg_i	(retire_old_preg_o)
);

`default_nettype wire

//--- bench/rename_core_tb.sv
//==========================================================================
// rename core testbench
// rows of dispatch and completion stimulus applied one per cycle
// a model of map, free list and rob gives the expected rename and
// retire outputs
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module rename_core_tb
	import rename_pkg::*;
;

	localparam int ROB_DEPTH = 16;
	localparam int ROB_IDX_W = $clog2(ROB_DEPTH);
	localparam int N_RANDOM = 80;

	typedef enum logic [1:0] {
		ROW_IDLE,
		ROW_DISPATCH,
		ROW_COMPLETE,		// cdb for one pending instr
		ROW_BOTH			// dispatch and cdb in one cycle
	} row_kind_e;

	typedef struct packed {
		row_kind_e	kind;
		areg_t		opa;
		areg_t		opb;
		areg_t		dest;
		logic [7:0]	sel;		// pick in the pending list
		logic		chk_dest;
		preg_t		exp_dest;
	} row_t;

	typedef struct packed {
		logic [ROB_IDX_W-1:0]	idx;
		areg_t					areg;
		preg_t					preg;
		preg_t					old_preg;
		logic					has_dest;
		logic					done;
	} rob_ent_t;

	typedef struct packed {
		logic [ROB_IDX_W-1:0]	idx;
		preg_t					tag;
	} pend_t;

	logic					clk = 1'b0;
	logic					rst_i;
	logic					dispatch_vld_i;
	areg_t					opa_areg_i;
	areg_t					opb_areg_i;
	areg_t					dest_areg_i;
	logic					cdb_vld_i;
	preg_t					cdb_tag_i;
	logic [ROB_IDX_W-1:0]	cdb_rob_idx_i;
	logic					dispatch_rdy_o;
	preg_t					opa_preg_o;
	preg_t					opb_preg_o;
	preg_t					dest_preg_o;
	logic					opa_rdy_o;
	logic					opb_rdy_o;
	logic [ROB_IDX_W-1:0]	rob_idx_o;
	logic					retire_vld_o;
	areg_t					retire_areg_o;
	preg_t					retire_preg_o;
	preg_t					retire_old_preg_o;
	logic					retire_has_dest_o;

	// reference model
	preg_t					m_map [N_AREG];
	logic [N_PREG-1:0]		m_rdy;
	preg_t					m_fl [$];
	rob_ent_t				m_rob [$];
	pend_t					m_pend [$];		// dispatched and not yet completed
	logic [ROB_IDX_W-1:0]	m_tail;

	row_t					table_q [$];
	integer					seed = 32'h3374;
	int						errors = 0;
	int						cycles = 0;
	int						limit = 0;		// set once the table is built

	rename_core #(
		.ROB_DEPTH	(ROB_DEPTH)
	) dut_i (.*);

	always #10 clk = ~clk;

	// run guard
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("timeout after %0d cycles, table never finished", cycles);
			$display("Verification failed");
			$finish;
		end
	end

	//==========================================================================
	// helpers
	//==========================================================================
	task automatic check_equal(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("Fail %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic add_row(input row_kind_e kind, input int a, input int b, input int d,
			input int sel, input int exp_dest);
		row_t r;
		r.kind		= kind;
		r.opa		= areg_t'(a);
		r.opb		= areg_t'(b);
		r.dest		= areg_t'(d);
		r.sel		= 8'(sel);
		r.chk_dest	= (exp_dest >= 0);
		r.exp_dest	= preg_t'(exp_dest);
		table_q.push_back(r);
	endtask

	task automatic reset_model();
		for (int i = 0; i < N_AREG; i++)
			m_map[i] = preg_t'(i);			// identity
		m_rdy = '1;
		m_fl.delete();
		for (int i = N_AREG; i < N_PREG; i++)
			m_fl.push_back(preg_t'(i));		// ascending free tags
		m_rob.delete();
		m_pend.delete();
		m_tail = '0;
	endtask

	// one cycle of drive, check before the edge and model step
	task automatic apply_row(input row_t r);
		logic		do_disp;
		logic		do_cdb;
		logic		has_dest;
		logic		exp_rdy;
		preg_t		exp_dest;
		preg_t		tag_a;
		preg_t		tag_b;
		pend_t		p;
		rob_ent_t	e;
		int			k;

		do_disp	= (r.kind == ROW_DISPATCH) || (r.kind == ROW_BOTH);
		do_cdb	= ((r.kind == ROW_COMPLETE) || (r.kind == ROW_BOTH)) && (m_pend.size() > 0);
		p		= '0;
		k		= 0;
		if (do_cdb) begin
			k = int'(r.sel) % m_pend.size();
			p = m_pend[k];
		end

		@(negedge clk);
		dispatch_vld_i	= do_disp;
		opa_areg_i		= r.opa;
		opb_areg_i		= r.opb;
		dest_areg_i		= r.dest;
		cdb_vld_i		= do_cdb;
		cdb_tag_i		= p.tag;
		cdb_rob_idx_i	= p.idx;

		has_dest	= (r.dest != areg_t'(ZERO_REG));
		exp_rdy		= (m_rob.size() < ROB_DEPTH) && !(has_dest && m_fl.size() == 0);
		exp_dest	= (has_dest && m_fl.size() > 0) ? m_fl[0] : m_map[ZERO_REG];
		tag_a		= m_map[r.opa];		// mapping before own dest update
		tag_b		= m_map[r.opb];

		#5;
		check_equal("dispatch_rdy_o", dispatch_rdy_o, exp_rdy);
		if (do_disp && exp_rdy) begin
			check_equal("opa_preg_o", opa_preg_o, tag_a);
			check_equal("opb_preg_o", opb_preg_o, tag_b);
			check_equal("opa_rdy_o", opa_rdy_o, m_rdy[tag_a] | (do_cdb && p.tag == tag_a));
			check_equal("opb_rdy_o", opb_rdy_o, m_rdy[tag_b] | (do_cdb && p.tag == tag_b));
			check_equal("dest_preg_o", dest_preg_o, exp_dest);
			check_equal("rob_idx_o", rob_idx_o, m_tail);
			if (r.chk_dest)
				check_equal("dest_preg_o", dest_preg_o, r.exp_dest);	// table value
		end
		if (m_rob.size() > 0 && m_rob[0].done) begin
			e = m_rob[0];
			check_equal("retire_vld_o", retire_vld_o, 1);
			check_equal("retire_areg_o", retire_areg_o, e.areg);
			check_equal("retire_preg_o", retire_preg_o, e.preg);
			check_equal("retire_has_dest_o", retire_has_dest_o, e.has_dest);
			if (e.has_dest)
				check_equal("retire_old_preg_o", retire_old_preg_o, e.old_preg);
		end else begin
			check_equal("retire_vld_o", retire_vld_o, 0);
		end

		// head retires on state before this edge's completion
		if (m_rob.size() > 0 && m_rob[0].done) begin
			e = m_rob.pop_front();
			if (e.has_dest)
				m_fl.push_back(e.old_preg);		// back at the fifo tail
		end
		if (do_cdb) begin
			m_rdy[p.tag] = 1'b1;
			for (int j = 0; j < m_rob.size(); j++) begin
				if (m_rob[j].idx == p.idx) begin
					e = m_rob[j];
					e.done = 1'b1;
					m_rob[j] = e;
				end
			end
			m_pend.delete(k);
		end
		if (do_disp && exp_rdy) begin
			e.idx		= m_tail;
			e.areg		= r.dest;
			e.preg		= exp_dest;
			e.old_preg	= m_map[r.dest];
			e.has_dest	= has_dest;
			e.done		= 1'b0;
			m_rob.push_back(e);
			p.idx = m_tail;
			p.tag = exp_dest;
			m_pend.push_back(p);
			m_tail = m_tail + 1'b1;
			if (has_dest) begin
				m_map[r.dest]	= exp_dest;
				m_rdy[exp_dest]	= 1'b0;			// cleared after any cdb set
				m_fl.delete(0);
			end
		end
	endtask

	//==========================================================================
	// stimulus table
	//==========================================================================
	task automatic build_table();
		int kind_bits;
		int d;

		// identity sources and dests from the reset free list
		add_row(ROW_DISPATCH, 1, 2, 5, 0, 32);
		add_row(ROW_DISPATCH, 3, 4, 6, 0, 33);
		add_row(ROW_DISPATCH, 5, 6, 5, 0, 34);		// r5 read as old tag 32
		add_row(ROW_BOTH, 6, 1, 7, 1, 35);			// tag 33 forwarded from cdb
		// zero reg dest consumes no tag
		add_row(ROW_DISPATCH, 31, 5, 31, 0, 31);
		add_row(ROW_DISPATCH, 2, 31, 31, 0, 31);
		add_row(ROW_DISPATCH, 7, 7, 9, 0, 36);
		// out of order completion
		add_row(ROW_COMPLETE, 0, 0, 31, 4, -1);
		add_row(ROW_COMPLETE, 0, 0, 31, 2, -1);
		add_row(ROW_IDLE, 0, 0, 31, 0, -1);
		for (int i = 0; i < 6; i++)
			add_row(ROW_COMPLETE, 0, 0, 31, 0, -1);
		for (int i = 0; i < 4; i++)
			add_row(ROW_IDLE, 0, 0, 31, 0, -1);

		// rob fills after 16 with no completions
		for (int i = 0; i < 18; i++)
			add_row(ROW_DISPATCH, i, i + 1, (i % 30) + 1, 0, -1);
		add_row(ROW_COMPLETE, 0, 0, 31, 15, -1);
		add_row(ROW_COMPLETE, 0, 0, 31, 0, -1);
		add_row(ROW_DISPATCH, 3, 4, 10, 0, -1);		// full through retire cycle
		for (int i = 0; i < 14; i++)
			add_row(ROW_BOTH, i + 2, 20 - i, (i % 7) + 11, 0, -1);
		for (int i = 0; i < 4; i++)
			add_row(ROW_IDLE, 0, 0, 31, 0, -1);

		// random mix
		for (int i = 0; i < N_RANDOM; i++) begin
			kind_bits = $random(seed) & 3;
			d = (($random(seed) & 7) == 0) ? ZERO_REG : ($random(seed) & 31);
			add_row(row_kind_e'(kind_bits), $random(seed) & 31, $random(seed) & 31, d,
				$random(seed) & 255, -1);
		end
	endtask

	//==========================================================================
	// main sequence
	//==========================================================================
	initial begin
		row_t drain_row;

		rst_i			= 1'b1;
		dispatch_vld_i	= 1'b0;
		opa_areg_i		= '0;
		opb_areg_i		= '0;
		dest_areg_i		= areg_t'(ZERO_REG);
		cdb_vld_i		= 1'b0;
		cdb_tag_i		= '0;
		cdb_rob_idx_i	= '0;

		build_table();
		limit = 4 * table_q.size() + 100;
		reset_model();

		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_i = 1'b0;

		foreach (table_q[i])
			apply_row(table_q[i]);

		// complete what is left until the rob is empty
		drain_row = '0;
		drain_row.kind = ROW_COMPLETE;
		drain_row.dest = areg_t'(ZERO_REG);
		while (m_rob.size() > 0)
			apply_row(drain_row);
		drain_row.kind = ROW_IDLE;
		apply_row(drain_row);

		$display("%0d rows, %0d cycles, %0d errors, %0d property failures", table_q.size(),
			cycles, errors, dut_i.props_i.fail_count);
		if (errors == 0 && dut_i.props_i.fail_count == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule : rename_core_tb

`default_nettype wire

//--- project.f
hw/rename_pkg.sv
hw/map_table.sv
hw/free_list.sv
hw/reorder_buffer.sv
hw/rename_core.sv
bench/rename_core_properties.sv
bench/rename_core_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = rename_core_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
